/* bp.f */
hdl/bp_isa_pkg.sv
hdl/bp_pred_pkg.sv
hdl/bp_btb.sv
hdl/bp_pht.sv
hdl/bp_ctrl.sv
hdl/bp_top.sv
verif/bp_tb.sv

/* hdl/bp_btb.sv */
// Branch target buffer, direct-mapped and tagged, read combinationally, written on the clock
module bp_btb #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                   clk,
    input  logic                   reset_i,
    // Lookup port, fetch side
    input  logic [31:0]            lookup_pc_i,
    output bp_pred_pkg::btb_hit_t  lookup_o,
    // Write port, driven from resolved transfers
    input  logic                   we_i,
    input  logic [31:0]            wpc_i,
    input  bp_isa_pkg::xfer_kind_e wkind_i,
    input  logic [31:0]            wtarget_i
);

    import bp_isa_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    // PC bits [1:0] are always zero, the rest above the index is tag
    localparam int TAG_BITS = 32 - IDX_BITS - 2;

    // Entry storage
    logic [TAG_BITS-1:0]        tag_q    [NUM_BTB_ENTRIES];
    logic [31:0]                target_q [NUM_BTB_ENTRIES];
    xfer_kind_e                 kind_q   [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] lidx;
    logic [TAG_BITS-1:0] ltag;
    logic [IDX_BITS-1:0] widx;
    logic [TAG_BITS-1:0] wtag;
    logic                lhit;

    // Split both PCs into index and tag
    assign lidx = lookup_pc_i[IDX_BITS+1:2];
    assign ltag = lookup_pc_i[31:IDX_BITS+2];
    assign widx = wpc_i[IDX_BITS+1:2];
    assign wtag = wpc_i[31:IDX_BITS+2];

    // Lookup sees the contents before any write in the same cycle
    assign lhit = valid_q[lidx] && (tag_q[lidx] == ltag);

    always_comb begin
        lookup_o.hit = lhit;
        if (lhit) begin
            lookup_o.kind   = kind_q[lidx];
            lookup_o.target = target_q[lidx];
        end else begin
            lookup_o.kind   = KIND_NONE;
            lookup_o.target = 32'd0;
        end
    end

    // Valid bits, cleared on reset
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[widx] <= 1'b1;
        end
    end

    // Entry payload
    // A write to an occupied slot simply evicts the old transfer
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[widx]    <= wtag;
            target_q[widx] <= wtarget_i;
            kind_q[widx]   <= wkind_i;
        end
    end

    // The control block only writes real transfers
    a_no_kind_none: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i |-> (wkind_i != KIND_NONE)
    ) else $error("BTB write with KIND_NONE");

endmodule

/* hdl/bp_ctrl.sv */
// Predictor control: forms the prediction, sequences table updates and flags mispredictions
module bp_ctrl #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic [31:0]            fetch_pc_i,
    input  bp_pred_pkg::resolve_t  resolve_i,
    input  logic                   ghr_clear_i,
    // Table read side
    input  bp_pred_pkg::btb_hit_t  btb_lookup_i,
    input  logic                   pht_taken_i,
    output bp_pred_pkg::pht_idx_t  pht_ridx_o,
    // BTB write side
    output logic                   btb_we_o,
    output logic [31:0]            btb_wpc_o,
    output bp_isa_pkg::xfer_kind_e btb_wkind_o,
    output logic [31:0]            btb_wtarget_o,
    // PHT update side
    output logic                   pht_we_o,
    output bp_pred_pkg::pht_idx_t  pht_widx_o,
    output logic                   pht_inc_o,
    // Fetch and execute results
    output bp_pred_pkg::predict_t  predict_o,
    output logic                   mispredict_o
);

    import bp_isa_pkg::*;
    import bp_pred_pkg::*;

    localparam int BTB_IDX_BITS = $clog2(NUM_BTB_ENTRIES);

    // BTB indexing in bp_btb assumes a power of two depth
    if (NUM_BTB_ENTRIES != (1 << BTB_IDX_BITS)) begin : g_depth_check
        $fatal(1, "NUM_BTB_ENTRIES must be a power of two");
    end

    pht_idx_t    ghr_q;
    pht_idx_t    ridx;
    logic [31:0] fall_through;
    logic        is_branch;
    logic        is_jump;
    logic        res_branch;
    logic        res_jump;
    logic        pred_taken;

    // Gshare read index
    assign ridx       = fetch_pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign pht_ridx_o = ridx;

    // Prediction select
    assign fall_through = fetch_pc_i + 32'd4;

    always_comb begin
        if (!btb_lookup_i.hit) begin
            pred_taken = 1'b0;
        end else if (btb_lookup_i.kind == KIND_JUMP) begin
            pred_taken = 1'b1;
        end else if (btb_lookup_i.kind == KIND_BRANCH) begin
            pred_taken = pht_taken_i;
        end else begin
            pred_taken = 1'b0;
        end
    end

    assign predict_o.taken   = pred_taken;
    assign predict_o.target  = pred_taken ? btb_lookup_i.target : fall_through;
    assign predict_o.pht_idx = ridx;

    // Resolve decode
    assign is_branch  = (resolve_i.op == OP_BRANCH);
    assign is_jump    = (resolve_i.op == OP_JAL) || (resolve_i.op == OP_JALR);
    assign res_branch = resolve_i.valid && is_branch;
    assign res_jump   = resolve_i.valid && is_jump;

    // BTB learns jumps and taken branches only
    assign btb_we_o      = res_jump || (res_branch && resolve_i.taken);
    assign btb_wpc_o     = resolve_i.pc;
    assign btb_wtarget_o = resolve_i.target;

    always_comb begin
        if (is_jump) begin
            btb_wkind_o = KIND_JUMP;
        end else if (is_branch) begin
            btb_wkind_o = KIND_BRANCH;
        end else begin
            btb_wkind_o = KIND_NONE;
        end
    end

    // Counter trained at the index used when the branch was fetched
    assign pht_we_o   = res_branch;
    assign pht_widx_o = resolve_i.pht_idx;
    assign pht_inc_o  = resolve_i.taken;

    // Global history, newest outcome enters at the top
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (res_branch) begin
            ghr_q <= {resolve_i.taken, ghr_q[GHR_BITS-1:1]};
        end
    end

    // Wrong direction, or both taken but to different places
    assign mispredict_o = (res_branch || res_jump) &&
                          ((resolve_i.taken != resolve_i.pred_taken) ||
                           (resolve_i.taken && resolve_i.pred_taken &&
                            (resolve_i.target != resolve_i.pred_target)));

    // Non-control resolves flag nothing and leave the predictor state alone
    a_other_quiet: assert property (
        @(posedge clk) disable iff (reset_i)
        resolve_i.valid && (resolve_i.op == OP_OTHER) && !ghr_clear_i
        |-> !mispredict_o && !btb_we_o && !pht_we_o ##1 $stable(ghr_q)
    ) else $error("OP_OTHER resolve disturbed the predictor");

endmodule

/* hdl/bp_isa_pkg.sv */
// RISC-V instruction set encodings seen by the branch predictor
package bp_isa_pkg;

    // Major opcodes, instruction bits [6:0]
    // Only the control transfer groups matter to the predictor,
    // anything else resolves as OP_OTHER
    typedef enum logic [6:0] {
        OP_OTHER  = 7'b0000000,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // Kind of control transfer held in a BTB entry
    // BRANCH entries consult the PHT, JUMP entries are always taken
    typedef enum logic [1:0] {
        KIND_NONE   = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JUMP   = 2'd2
    } xfer_kind_e;

endpackage

/* hdl/bp_pht.sv */
// Gshare pattern history table of 2-bit saturating counters
module bp_pht (
    input  logic                  clk,
    input  logic                  reset_i,
    // Read port, indexed by PC xor history
    input  bp_pred_pkg::pht_idx_t ridx_i,
    output logic                  taken_o,
    // Update port from resolved branches
    input  logic                  we_i,
    input  bp_pred_pkg::pht_idx_t widx_i,
    input  logic                  inc_i
);

    import bp_pred_pkg::*;

    localparam int NUM_CNT = 1 << GHR_BITS;

    // 00 strong NT, 01 weak NT, 10 weak T, 11 strong T
    logic [1:0] cnt_q [NUM_CNT];

    // Prediction is the counter MSB
    assign taken_o = cnt_q[ridx_i][1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            // Everything starts weakly not taken
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt_q[i] <= 2'b01;
            end
        end else if (we_i) begin
            if (inc_i) begin
                if (cnt_q[widx_i] != 2'b11) begin
                    cnt_q[widx_i] <= cnt_q[widx_i] + 2'd1;
                end
            end else begin
                if (cnt_q[widx_i] != 2'b00) begin
                    cnt_q[widx_i] <= cnt_q[widx_i] - 2'd1;
                end
            end
        end
    end

    // A counter at its limit stays there when pushed further
    a_saturate: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i && (cnt_q[widx_i] == (inc_i ? 2'b11 : 2'b00))
        |=> cnt_q[$past(widx_i)] == $past(cnt_q[widx_i])
    ) else $error("PHT counter wrapped");

endmodule

/* hdl/bp_pred_pkg.sv */
// Predictor packet formats shared by fetch, execute and the predictor blocks
package bp_pred_pkg;

    // Global history length, also the PHT index width (32 counters)
    localparam int GHR_BITS = 5;

    typedef logic [GHR_BITS-1:0] pht_idx_t;

    // Prediction returned to fetch in the same cycle
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        // Index used for this prediction, carried down the pipe
        pht_idx_t    pht_idx;
    } predict_t;

    // Outcome packet from execute, one cycle valid strobe
    typedef struct packed {
        logic                valid;
        logic [31:0]         pc;
        bp_isa_pkg::opcode_e op;
        // Actual outcome
        logic                taken;
        logic [31:0]         target;
        // What fetch was told for this instruction
        pht_idx_t            pht_idx;
        logic                pred_taken;
        logic [31:0]         pred_target;
    } resolve_t;

    // Result of a BTB lookup
    typedef struct packed {
        logic                   hit;
        bp_isa_pkg::xfer_kind_e kind;
        logic [31:0]            target;
    } btb_hit_t;

endpackage

/* hdl/bp_top.sv */
// Fetch-stage branch predictor top level with control, BTB and gshare PHT
module bp_top #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic [31:0]           fetch_pc_i,
    input  bp_pred_pkg::resolve_t resolve_i,
    input  logic                  ghr_clear_i,
    output bp_pred_pkg::predict_t predict_o,
    output logic                  mispredict_o
);

    import bp_isa_pkg::*;
    import bp_pred_pkg::*;

    // Lookup path
    btb_hit_t    btb_lookup;
    logic        pht_taken;
    pht_idx_t    pht_ridx;

    // Update path
    logic        btb_we;
    logic [31:0] btb_wpc;
    xfer_kind_e  btb_wkind;
    logic [31:0] btb_wtarget;
    logic        pht_we;
    pht_idx_t    pht_widx;
    logic        pht_inc;

    bp_ctrl #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .fetch_pc_i    (fetch_pc_i),
        .resolve_i     (resolve_i),
        .ghr_clear_i   (ghr_clear_i),
        .btb_lookup_i  (btb_lookup),
        .pht_taken_i   (pht_taken),
        .pht_ridx_o    (pht_ridx),
        .btb_we_o      (btb_we),
        .btb_wpc_o     (btb_wpc),
        .btb_wkind_o   (btb_wkind),
        .btb_wtarget_o (btb_wtarget),
        .pht_we_o      (pht_we),
        .pht_widx_o    (pht_widx),
        .pht_inc_o     (pht_inc),
        .predict_o     (predict_o),
        .mispredict_o  (mispredict_o)
    );

    bp_btb #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .lookup_pc_i (fetch_pc_i),
        .lookup_o    (btb_lookup),
        .we_i        (btb_we),
        .wpc_i       (btb_wpc),
        .wkind_i     (btb_wkind),
        .wtarget_i   (btb_wtarget)
    );

    bp_pht u_pht (
        .clk     (clk),
        .reset_i (reset_i),
        .ridx_i  (pht_ridx),
        .taken_o (pht_taken),
        .we_i    (pht_we),
        .widx_i  (pht_widx),
        .inc_i   (pht_inc)
    );

endmodule

/* verif/bp_tb.sv */
// Directed testbench for the branch predictor with a reference model of BTB, PHT and history
module bp_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import bp_isa_pkg::*;
    import bp_pred_pkg::*;

    localparam int BTB_DEPTH     = 32;
    localparam int BTB_IDX       = $clog2(BTB_DEPTH);
    localparam int NUM_CNT       = 1 << GHR_BITS;
    localparam int CLK_PERIOD_NS = 4;
    localparam int RESET_CYCLES  = 16;

    // Cycle budget of each test, used by the watchdog
    localparam int N_RESET_PCS    = 16;
    localparam int N_BRANCH_ITERS = 10;
    localparam int N_GHR_STEPS    = 8;
    localparam int TEST_CYCLES    = RESET_CYCLES + N_RESET_PCS + 5 + 3 * N_BRANCH_ITERS
                                    + 2 + 2 * N_GHR_STEPS + 4 + 7 + 7 + 2;
    localparam int MARGIN_CYCLES  = 50;
    localparam int TIMEOUT_NS     = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS;

    logic        clk = 1'b0;
    logic        reset_i;
    logic [31:0] fetch_pc_i;
    resolve_t    resolve_i;
    logic        ghr_clear_i;
    predict_t    predict_o;
    logic        mispredict_o;

    integer seed = 32'h84ad_3fdf;
    int     err_count = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    // Reference model state
    logic        m_valid  [BTB_DEPTH];
    logic [31:0] m_pc     [BTB_DEPTH];
    xfer_kind_e  m_kind   [BTB_DEPTH];
    logic [31:0] m_target [BTB_DEPTH];
    logic [1:0]  m_cnt    [NUM_CNT];
    pht_idx_t    m_ghr;

    always #2 clk = ~clk;

    bp_top #(
        .NUM_BTB_ENTRIES (BTB_DEPTH)
    ) u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_pc_i   (fetch_pc_i),
        .resolve_i    (resolve_i),
        .ghr_clear_i  (ghr_clear_i),
        .predict_o    (predict_o),
        .mispredict_o (mispredict_o)
    );

    task automatic check_value(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            err_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", test, expected, actual);
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("%s: ok", test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", test, err_count - errs_before);
        end
    endtask

    function automatic logic [31:0] random_aligned();
        return $random(seed) & 32'hffff_fffc;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < BTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        for (int i = 0; i < NUM_CNT; i++) begin
            m_cnt[i] = 2'b01;
        end
        m_ghr = '0;
    endtask

    function automatic predict_t model_predict(input logic [31:0] pc);
        predict_t p;
        int       bi;
        logic     hit;
        bi  = pc[BTB_IDX+1:2];
        hit = m_valid[bi] && (m_pc[bi][31:BTB_IDX+2] == pc[31:BTB_IDX+2]);
        p.pht_idx = pc[GHR_BITS+1:2] ^ m_ghr;
        if (!hit) begin
            p.taken = 1'b0;
        end else if (m_kind[bi] == KIND_JUMP) begin
            p.taken = 1'b1;
        end else begin
            p.taken = m_cnt[p.pht_idx][1];
        end
        p.target = p.taken ? m_target[bi] : pc + 32'd4;
        return p;
    endfunction

    function automatic logic model_mispredict(input resolve_t r);
        logic ctl;
        ctl = (r.op == OP_BRANCH) || (r.op == OP_JAL) || (r.op == OP_JALR);
        return r.valid && ctl && ((r.taken != r.pred_taken) ||
                                  (r.taken && r.pred_taken && (r.target != r.pred_target)));
    endfunction

    // State as it will be after the edge that consumes the packet
    task automatic model_update(input resolve_t r);
        int   bi;
        logic is_br;
        logic is_jmp;
        bi     = r.pc[BTB_IDX+1:2];
        is_br  = (r.op == OP_BRANCH);
        is_jmp = (r.op == OP_JAL) || (r.op == OP_JALR);
        if (r.valid && (is_jmp || (is_br && r.taken))) begin
            m_valid[bi]  = 1'b1;
            m_pc[bi]     = r.pc;
            m_target[bi] = r.target;
            if (is_jmp) begin
                m_kind[bi] = KIND_JUMP;
            end else begin
                m_kind[bi] = KIND_BRANCH;
            end
        end
        if (r.valid && is_br) begin
            if (r.taken && (m_cnt[r.pht_idx] != 2'b11)) begin
                m_cnt[r.pht_idx] = m_cnt[r.pht_idx] + 2'd1;
            end else if (!r.taken && (m_cnt[r.pht_idx] != 2'b00)) begin
                m_cnt[r.pht_idx] = m_cnt[r.pht_idx] - 2'd1;
            end
            m_ghr = {r.taken, m_ghr[GHR_BITS-1:1]};
        end
    endtask

    function automatic resolve_t make_resolve(input logic [31:0] pc, input opcode_e op,
                                              input logic taken, input logic [31:0] target,
                                              input pht_idx_t idx, input logic pred_taken,
                                              input logic [31:0] pred_target);
        resolve_t r;
        r.valid       = 1'b1;
        r.pc          = pc;
        r.op          = op;
        r.taken       = taken;
        r.target      = target;
        r.pht_idx     = idx;
        r.pred_taken  = pred_taken;
        r.pred_target = pred_target;
        return r;
    endfunction

    task automatic lookup_check(input string test, input logic [31:0] pc, output predict_t p);
        @(posedge clk);
        fetch_pc_i  <= pc;
        resolve_i   <= '0;
        ghr_clear_i <= 1'b0;
        @(negedge clk);
        p = predict_o;
        check_value(test, model_predict(pc), p);
    endtask

    task automatic send_resolve(input string test, input resolve_t r, output logic mp);
        @(posedge clk);
        resolve_i   <= r;
        ghr_clear_i <= 1'b0;
        @(negedge clk);
        mp = mispredict_o;
        check_value(test, model_mispredict(r), mp);
        model_update(r);
    endtask

    task automatic clear_history();
        @(posedge clk);
        resolve_i   <= '0;
        ghr_clear_i <= 1'b1;
        @(negedge clk);
        m_ghr = '0;
    endtask

    task automatic test_after_reset();
        int          errs;
        logic [31:0] pc;
        predict_t    p;
        errs = err_count;
        for (int i = 0; i < N_RESET_PCS; i++) begin
            pc = random_aligned();
            lookup_check("after_reset", pc, p);
            check_value("after_reset", {1'b0, pc + 32'd4}, {p.taken, p.target});
            check_value("after_reset", 1'b0, mispredict_o);
        end
        report_test("after_reset", errs);
    endtask

    task automatic test_jump_learning();
        int          errs;
        logic [31:0] pc;
        logic [31:0] tgt;
        predict_t    p;
        logic        mp;
        errs = err_count;
        pc   = random_aligned();
        tgt  = random_aligned();
        lookup_check("jump_learning", pc, p);
        send_resolve("jump_learning", make_resolve(pc, OP_JAL, 1'b1, tgt, p.pht_idx,
                                                   p.taken, p.target), mp);
        lookup_check("jump_learning", pc, p);
        check_value("jump_learning", {1'b1, tgt}, {p.taken, p.target});
        // JALR to a new place replaces the stored target
        tgt = random_aligned();
        send_resolve("jump_learning", make_resolve(pc, OP_JALR, 1'b1, tgt, p.pht_idx,
                                                   p.taken, p.target), mp);
        lookup_check("jump_learning", pc, p);
        check_value("jump_learning", {1'b1, tgt}, {p.taken, p.target});
        report_test("jump_learning", errs);
    endtask

    task automatic test_branch_history();
        int          errs;
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [31:0] dest;
        predict_t    p;
        logic        mp;
        // Outcome per iteration, and the direction expected before it
        logic [N_BRANCH_ITERS-1:0] outcome  = 10'b11_1000_0111;
        logic [N_BRANCH_ITERS-1:0] exp_pred = 10'b10_0001_1110;
        errs = err_count;
        pc   = random_aligned();
        tgt  = random_aligned();
        for (int i = 0; i < N_BRANCH_ITERS; i++) begin
            // Clearing history keeps the branch on one counter
            clear_history();
            lookup_check("branch_history", pc, p);
            check_value("branch_history", exp_pred[i], p.taken);
            dest = outcome[i] ? tgt : pc + 32'd4;
            send_resolve("branch_history", make_resolve(pc, OP_BRANCH, outcome[i], dest,
                                                        p.pht_idx, p.taken, p.target), mp);
        end
        report_test("branch_history", errs);
    endtask

    task automatic test_ghr_effect();
        int          errs;
        logic [31:0] pc;
        logic [31:0] tgt;
        pht_idx_t    exp_ghr;
        logic        taken;
        predict_t    p;
        logic        mp;
        errs    = err_count;
        pc      = random_aligned();
        tgt     = random_aligned();
        exp_ghr = '0;
        clear_history();
        lookup_check("ghr_effect", pc, p);
        check_value("ghr_effect", pc[GHR_BITS+1:2], p.pht_idx);
        for (int i = 0; i < N_GHR_STEPS; i++) begin
            taken = $random(seed);
            send_resolve("ghr_effect", make_resolve(pc, OP_BRANCH, taken,
                                                    taken ? tgt : pc + 32'd4,
                                                    p.pht_idx, p.taken, p.target), mp);
            exp_ghr = {taken, exp_ghr[GHR_BITS-1:1]};
            lookup_check("ghr_effect", pc, p);
            check_value("ghr_effect", pc[GHR_BITS+1:2] ^ exp_ghr, p.pht_idx);
        end
        clear_history();
        lookup_check("ghr_effect", pc, p);
        check_value("ghr_effect", pc[GHR_BITS+1:2], p.pht_idx);
        report_test("ghr_effect", errs);
    endtask

    task automatic test_btb_aliasing();
        int          errs;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        logic [31:0] tgt_a;
        logic [31:0] tgt_b;
        predict_t    p;
        logic        mp;
        errs  = err_count;
        pc_a  = random_aligned();
        // Same BTB slot, lowest tag bit flipped
        pc_b  = pc_a ^ (32'd1 << (BTB_IDX + 2));
        tgt_a = random_aligned();
        tgt_b = random_aligned();
        lookup_check("btb_aliasing", pc_a, p);
        send_resolve("btb_aliasing", make_resolve(pc_a, OP_JAL, 1'b1, tgt_a, p.pht_idx,
                                                  p.taken, p.target), mp);
        lookup_check("btb_aliasing", pc_a, p);
        check_value("btb_aliasing", {1'b1, tgt_a}, {p.taken, p.target});
        lookup_check("btb_aliasing", pc_b, p);
        check_value("btb_aliasing", {1'b0, pc_b + 32'd4}, {p.taken, p.target});
        send_resolve("btb_aliasing", make_resolve(pc_b, OP_JAL, 1'b1, tgt_b, p.pht_idx,
                                                  p.taken, p.target), mp);
        lookup_check("btb_aliasing", pc_b, p);
        check_value("btb_aliasing", {1'b1, tgt_b}, {p.taken, p.target});
        lookup_check("btb_aliasing", pc_a, p);
        check_value("btb_aliasing", {1'b0, pc_a + 32'd4}, {p.taken, p.target});
        report_test("btb_aliasing", errs);
    endtask

    task automatic test_mispredict_flag();
        int          errs;
        logic [31:0] pc;
        logic [31:0] tgt;
        logic [31:0] seq;
        predict_t    p;
        logic        mp;
        errs = err_count;
        pc   = random_aligned();
        tgt  = random_aligned();
        seq  = pc + 32'd4;
        // Wrong direction both ways
        send_resolve("mispredict_flag", make_resolve(pc, OP_BRANCH, 1'b1, tgt, '0,
                                                     1'b0, seq), mp);
        check_value("mispredict_flag", 1'b1, mp);
        send_resolve("mispredict_flag", make_resolve(pc, OP_BRANCH, 1'b0, seq, '0,
                                                     1'b1, tgt), mp);
        check_value("mispredict_flag", 1'b1, mp);
        // Right direction, wrong target
        send_resolve("mispredict_flag", make_resolve(pc, OP_JAL, 1'b1, tgt, '0,
                                                     1'b1, tgt ^ 32'h100), mp);
        check_value("mispredict_flag", 1'b1, mp);
        // Correct predictions
        send_resolve("mispredict_flag", make_resolve(pc, OP_JALR, 1'b1, tgt, '0,
                                                     1'b1, tgt), mp);
        check_value("mispredict_flag", 1'b0, mp);
        send_resolve("mispredict_flag", make_resolve(pc, OP_BRANCH, 1'b0, seq, '0,
                                                     1'b0, seq), mp);
        check_value("mispredict_flag", 1'b0, mp);
        // Not a control transfer, so never flagged
        send_resolve("mispredict_flag", make_resolve(pc, OP_OTHER, 1'b1, tgt, '0,
                                                     1'b0, seq), mp);
        check_value("mispredict_flag", 1'b0, mp);
        lookup_check("mispredict_flag", pc, p);
        report_test("mispredict_flag", errs);
    endtask

    initial begin
        reset_i     = 1'b1;
        fetch_pc_i  = '0;
        resolve_i   = '0;
        ghr_clear_i = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;

        test_after_reset();
        test_jump_learning();
        test_branch_history();
        test_ghr_effect();
        test_btb_aliasing();
        test_mispredict_flag();

        @(posedge clk);
        resolve_i <= '0;
        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

endmodule
